//--- logic/board_bus_if.sv
`timescale 1ns/1ps

interface board_bus_if;

    logic                             req;
    logic                             we;
    logic [playfield_pkg::row_aw-1:0] addr;
    logic [playfield_pkg::board_w-1:0] wdata;
    logic                             gnt;
    logic [playfield_pkg::board_w-1:0] rdata; // valid the cycle after a read gnt

    modport requester
    (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport store
    (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

//--- logic/board_store.sv
`timescale 1ns/1ps

module board_store
(
    input  logic       clk,
    input  logic       arst_n,
    board_bus_if.store bus [playfield_pkg::n_req]
);

    logic [playfield_pkg::board_w-1:0] rows [playfield_pkg::board_h];
    logic [playfield_pkg::n_req-1:0]   req;
    logic [playfield_pkg::n_req-1:0]   gnt;
    logic [playfield_pkg::n_req-1:0]   we;
    logic [playfield_pkg::row_aw-1:0]  addr [playfield_pkg::n_req];
    logic [playfield_pkg::board_w-1:0] wdata [playfield_pkg::n_req];
    logic [playfield_pkg::board_w-1:0] rdata_q;

    for (genvar i = 0; i < playfield_pkg::n_req; i++)
    begin : g_port
        assign req[i]       = bus[i].req;
        assign we[i]        = bus[i].we;
        assign addr[i]      = bus[i].addr;
        assign wdata[i]     = bus[i].wdata;
        assign bus[i].gnt   = gnt[i];
        assign bus[i].rdata = rdata_q;
    end

    assign gnt = req & (~req + 1'b1); // lowest asking index wins

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rows <= '{default: '0};
        end
        else
        begin
            for (int i = 0; i < playfield_pkg::n_req; i++)
            begin
                if (gnt[i] && we[i])
                    rows[addr[i]] <= wdata[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < playfield_pkg::n_req; i++)
        begin
            if (gnt[i] && !we[i])
                rdata_q <= rows[addr[i]];
        end
    end

    // a granted requester leaves the bus free for the next cycle
    for (genvar i = 0; i < playfield_pkg::n_req; i++)
    begin : g_drop
        assert property (@(posedge clk) disable iff (!arst_n) gnt[i] |=> !req[i]);
    end

endmodule

//--- logic/line_clearer.sv
`timescale 1ns/1ps

module line_clearer
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           merge_done,
    output logic           clear_done,
    output logic [2:0]     lines_cleared,
    board_bus_if.requester bus
);

    enum logic [2:0] {st_idle, st_rd, st_chk, st_wr, st_adv, st_zero, st_zadv} state;

    logic [playfield_pkg::row_aw-1:0]  src;
    logic [playfield_pkg::row_aw-1:0]  dst;
    logic [playfield_pkg::board_w-1:0] row_q;

    assign bus.req   = (state == st_rd) || (state == st_wr) || (state == st_zero);
    assign bus.we    = (state == st_wr) || (state == st_zero);
    assign bus.addr  = (state == st_rd) ? src : dst;
    assign bus.wdata = (state == st_wr) ? row_q : '0;

    always_ff @(posedge clk)
    begin
        if (state == st_chk)
            row_q <= bus.rdata;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state         <= st_idle;
            src           <= '0;
            dst           <= '0;
            lines_cleared <= '0;
            clear_done    <= 1'b0;
        end
        else
        begin
            clear_done <= 1'b0;
            case (state)
                st_idle:
                    if (merge_done)
                    begin
                        src           <= playfield_pkg::row_aw'(playfield_pkg::board_h - 1);
                        dst           <= playfield_pkg::row_aw'(playfield_pkg::board_h - 1);
                        lines_cleared <= '0;
                        state         <= st_rd;
                    end
                st_rd:
                    if (bus.gnt)
                        state <= st_chk;
                st_chk:
                    if (&bus.rdata)
                    begin
                        lines_cleared <= lines_cleared + 3'd1; // full row is dropped
                        state         <= st_adv;
                    end
                    else if (lines_cleared == 3'd0)
                    begin
                        dst   <= dst - 1'b1; // nothing removed below, row stays put
                        state <= st_adv;
                    end
                    else
                        state <= st_wr;
                st_wr:
                    if (bus.gnt)
                    begin
                        dst   <= dst - 1'b1;
                        state <= st_adv;
                    end
                st_adv:
                    if (src == '0)
                    begin
                        if (lines_cleared == 3'd0)
                        begin
                            clear_done <= 1'b1;
                            state      <= st_idle;
                        end
                        else
                            state <= st_zero; // rows dst down to 0 are stale
                    end
                    else
                    begin
                        src   <= src - 1'b1;
                        state <= st_rd;
                    end
                st_zero:
                    if (bus.gnt)
                        state <= st_zadv;
                st_zadv:
                    if (dst == '0)
                    begin
                        clear_done <= 1'b1;
                        state      <= st_idle;
                    end
                    else
                    begin
                        dst   <= dst - 1'b1;
                        state <= st_zero;
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

endmodule

//--- logic/move_checker.sv
`timescale 1ns/1ps

module move_checker
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           check,
    input  logic [1:0]                     dir,
    input  logic [playfield_pkg::px_w-1:0] piece_x,
    input  logic [playfield_pkg::px_w-1:0] piece_y,
    input  logic [15:0]                    shape,
    output logic                           check_done,
    output logic                           move_ok,
    board_bus_if.requester                 bus
);

    enum logic [1:0] {st_idle, st_eval, st_req, st_wait} state;

    logic [15:0]       shape_q;
    logic signed [7:0] col_q;
    logic [6:0]        row_q;
    logic [1:0]        r_idx;
    logic [3:0]        cells;
    logic              in_bounds;
    logic              hit;
    logic              check_seen;

    assign cells = shape_q[4*r_idx +: 4];
    assign hit   = |(bus.rdata & playfield_pkg::align_row(cells, col_q));

    always_comb
    begin
        in_bounds = 1'b1;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                if (shape_q[4*r+c] && (col_q + c < 0 || col_q + c >= playfield_pkg::board_w
                                       || row_q + r >= playfield_pkg::board_h))
                    in_bounds = 1'b0;
            end
        end
    end

    assign bus.req   = (state == st_req) && (cells != 4'd0);
    assign bus.we    = 1'b0;
    assign bus.addr  = playfield_pkg::row_aw'(row_q + 7'(r_idx));
    assign bus.wdata = '0;

    always_ff @(posedge clk)
    begin
        if (state == st_idle && check)
        begin
            shape_q <= shape;
            col_q   <= playfield_pkg::col_of(piece_x);
            row_q   <= playfield_pkg::row_of(piece_y);
            case (dir)
                playfield_pkg::dir_spawn: ; // checked where it stands
                playfield_pkg::dir_down:  row_q <= playfield_pkg::row_of(piece_y) + 7'd1;
                playfield_pkg::dir_left:  col_q <= playfield_pkg::col_of(piece_x) - 8'sd1;
                playfield_pkg::dir_right: col_q <= playfield_pkg::col_of(piece_x) + 8'sd1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= st_idle;
            r_idx      <= '0;
            check_done <= 1'b0;
            move_ok    <= 1'b0;
        end
        else
        begin
            check_done <= 1'b0;
            case (state)
                st_idle:
                    if (check)
                    begin
                        r_idx <= '0;
                        state <= st_eval;
                    end
                st_eval:
                    if (!in_bounds)
                    begin
                        move_ok    <= 1'b0; // wall or floor, no board access needed
                        check_done <= 1'b1;
                        state      <= st_idle;
                    end
                    else
                        state <= st_req;
                st_req:
                    if (cells == 4'd0)
                    begin
                        if (r_idx == 2'd3)
                        begin
                            move_ok    <= 1'b1;
                            check_done <= 1'b1;
                            state      <= st_idle;
                        end
                        r_idx <= r_idx + 2'd1;
                    end
                    else if (bus.gnt)
                        state <= st_wait;
                st_wait:
                    if (hit || r_idx == 2'd3)
                    begin
                        move_ok    <= !hit;
                        check_done <= 1'b1;
                        state      <= st_idle;
                    end
                    else
                    begin
                        r_idx <= r_idx + 2'd1;
                        state <= st_req;
                    end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            check_seen <= 1'b0;
        else if (check)
            check_seen <= 1'b1;
        else if (check_done)
            check_seen <= 1'b0;
    end

    assert property (@(posedge clk) disable iff (!arst_n) check_done |-> check_seen);

endmodule

//--- logic/piece_locker.sv
`timescale 1ns/1ps

module piece_locker
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           lock,
    input  logic [playfield_pkg::px_w-1:0] piece_x,
    input  logic [playfield_pkg::px_w-1:0] piece_y,
    input  logic [15:0]                    shape,
    input  logic                           clear_done,
    output logic                           merge_done,
    output logic                           busy,
    board_bus_if.requester                 bus
);

    enum logic [2:0] {st_idle, st_rd, st_mrg, st_wr, st_adv, st_hold} state;

    logic [15:0]                       shape_q;
    logic signed [7:0]                 col_q;
    logic [6:0]                        row_q;
    logic [1:0]                        r_idx;
    logic [3:0]                        cells;
    logic [playfield_pkg::board_w-1:0] merged_q;

    assign cells = shape_q[4*r_idx +: 4];
    assign busy  = (state != st_idle); // held until the clearer reports back

    assign bus.req   = (state == st_rd && cells != 4'd0) || (state == st_wr);
    assign bus.we    = (state == st_wr);
    assign bus.addr  = playfield_pkg::row_aw'(row_q + 7'(r_idx));
    assign bus.wdata = merged_q;

    always_ff @(posedge clk)
    begin
        if (state == st_idle && lock)
        begin
            shape_q <= shape;
            col_q   <= playfield_pkg::col_of(piece_x);
            row_q   <= playfield_pkg::row_of(piece_y);
        end
        if (state == st_mrg)
            merged_q <= bus.rdata | playfield_pkg::align_row(cells, col_q);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= st_idle;
            r_idx      <= '0;
            merge_done <= 1'b0;
        end
        else
        begin
            merge_done <= 1'b0;
            case (state)
                st_idle:
                    if (lock)
                    begin
                        r_idx <= '0;
                        state <= st_rd;
                    end
                st_rd:
                    if (cells == 4'd0)
                        state <= st_adv;
                    else if (bus.gnt)
                        state <= st_mrg;
                st_mrg:
                    state <= st_wr;
                st_wr:
                    if (bus.gnt)
                        state <= st_adv; // gives the bus a free cycle
                st_adv:
                    if (r_idx == 2'd3)
                    begin
                        merge_done <= 1'b1;
                        state      <= st_hold;
                    end
                    else
                    begin
                        r_idx <= r_idx + 2'd1;
                        state <= st_rd;
                    end
                st_hold:
                    if (clear_done)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        bus.gnt && bus.we |-> bus.addr < playfield_pkg::board_h);

endmodule

//--- logic/playfield_pkg.sv
package playfield_pkg;

    localparam int board_w  = 10;
    localparam int board_h  = 24;
    localparam int cell_px  = 20;
    localparam int x_origin = 80;
    localparam int row_aw   = 5;
    localparam int px_w     = 10;

    localparam logic [1:0] dir_spawn = 2'd0;
    localparam logic [1:0] dir_down  = 2'd1;
    localparam logic [1:0] dir_left  = 2'd2;
    localparam logic [1:0] dir_right = 2'd3;

    localparam int req_clear = 0; // highest priority
    localparam int req_lock  = 1;
    localparam int req_check = 2;
    localparam int n_req     = 3;

    // board column of a pixel x, negative left of the board
    function automatic logic signed [7:0] col_of(input logic [px_w-1:0] x);
        return 8'(($signed({1'b0, x}) - x_origin) / cell_px);
    endfunction

    function automatic logic [6:0] row_of(input logic [px_w-1:0] y);
        return 7'(y / cell_px);
    endfunction

    // places a four-cell shape row at column col of a board row
    function automatic logic [board_w-1:0] align_row(input logic [3:0] cells,
                                                     input logic signed [7:0] col);
        logic [board_w+5:0] wide;
        wide = (board_w + 6)'(cells) << (col + 8'sd3);
        return wide[board_w+2:3];
    endfunction

endpackage

//--- logic/playfield_top.sv
`timescale 1ns/1ps

module playfield_top
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           check,
    input  logic                           lock,
    input  logic [1:0]                     dir,
    input  logic [playfield_pkg::px_w-1:0] piece_x,
    input  logic [playfield_pkg::px_w-1:0] piece_y,
    input  logic [15:0]                    shape,
    output logic                           check_done,
    output logic                           move_ok,
    output logic                           lock_done,
    output logic [2:0]                     lines_cleared,
    output logic                           busy
);

    logic merge_done;

    board_bus_if u_bus [playfield_pkg::n_req] ();

    board_store u_board_store
    (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (u_bus)
    );

    move_checker u_move_checker
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .check      (check),
        .dir        (dir),
        .piece_x    (piece_x),
        .piece_y    (piece_y),
        .shape      (shape),
        .check_done (check_done),
        .move_ok    (move_ok),
        .bus        (u_bus[playfield_pkg::req_check])
    );

    piece_locker u_piece_locker
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .lock       (lock),
        .piece_x    (piece_x),
        .piece_y    (piece_y),
        .shape      (shape),
        .clear_done (lock_done),
        .merge_done (merge_done),
        .busy       (busy),
        .bus        (u_bus[playfield_pkg::req_lock])
    );

    line_clearer u_line_clearer
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .merge_done    (merge_done),
        .clear_done    (lock_done), // end of the clear pass ends the lock
        .lines_cleared (lines_cleared),
        .bus           (u_bus[playfield_pkg::req_clear])
    );

endmodule

//--- playfield_top.f
logic/playfield_pkg.sv
logic/board_bus_if.sv
logic/board_store.sv
logic/move_checker.sv
logic/piece_locker.sv
logic/line_clearer.sv
logic/playfield_top.sv
sim/playfield_tb.sv

//--- sim/playfield_tb.sv
`timescale 1ns/1ps

module playfield_tb;

    localparam int max_cycles = 40000; // 300 operations of up to 120 cycles, with margin

    logic        clk;
    logic        arst_n;
    logic        check;
    logic        lock;
    logic [1:0]  dir;
    logic [9:0]  piece_x;
    logic [9:0]  piece_y;
    logic [15:0] shape;
    logic        check_done;
    logic        move_ok;
    logic        lock_done;
    logic [2:0]  lines_cleared;
    logic        busy;

    logic [15:0] lfsr;
    logic [9:0]  ref_board [24]; // bit j of a row is column j
    bit          exp_ok;
    bit          exp_fast;
    int          exp_lines;
    string       test_name;
    string       lock_name;
    int          cycles;

    playfield_top u_playfield_top
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .check         (check),
        .lock          (lock),
        .dir           (dir),
        .piece_x       (piece_x),
        .piece_y       (piece_y),
        .shape         (shape),
        .check_done    (check_done),
        .move_ok       (move_ok),
        .lock_done     (lock_done),
        .lines_cleared (lines_cleared),
        .busy          (busy)
    );

    task automatic fail_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            v    = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // every set cell of the box at pixel (tx, ty) lies on the board
    function automatic bit fits(input int tx, input int ty, input logic [15:0] shp);
        int col;
        int row;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                col = (tx - playfield_pkg::x_origin) / playfield_pkg::cell_px + c;
                row = ty / playfield_pkg::cell_px + r;
                if (shp[4*r+c] && (col < 0 || col > 9 || row > 23))
                    return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic bit hits(input int tx, input int ty, input logic [15:0] shp);
        int col;
        int row;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                col = (tx - playfield_pkg::x_origin) / playfield_pkg::cell_px + c;
                row = ty / playfield_pkg::cell_px + r;
                if (shp[4*r+c] && ref_board[row][col])
                    return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic do_check(input string name, input int col, input int row,
                            input logic [1:0] d, input logic [15:0] shp);
        int tx;
        int ty;
        tx = playfield_pkg::x_origin + playfield_pkg::cell_px * col;
        ty = playfield_pkg::cell_px * row;
        case (d)
            playfield_pkg::dir_down:  ty = ty + playfield_pkg::cell_px;
            playfield_pkg::dir_left:  tx = tx - playfield_pkg::cell_px;
            playfield_pkg::dir_right: tx = tx + playfield_pkg::cell_px;
            default: ;
        endcase
        exp_fast  = !fits(tx, ty, shp);
        exp_ok    = !exp_fast && !hits(tx, ty, shp);
        test_name = name;
        piece_x   = 10'(playfield_pkg::x_origin + playfield_pkg::cell_px * col);
        piece_y   = 10'(playfield_pkg::cell_px * row);
        dir       = d;
        shape     = shp;
        check     = 1'b1;
        @(negedge clk);
        check = 1'b0;
        while (!check_done)
            @(negedge clk);
        @(negedge clk); // the move_ok assertion samples at the edge before this one
    endtask

    // merges the piece into the reference board and compacts it from the bottom
    task automatic lock_model(input int col0, input int row0, input logic [15:0] shp,
                              output int n);
        logic [9:0] nb [24];
        int         dst;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                if (shp[4*r+c])
                    ref_board[row0+r][col0+c] = 1'b1;
            end
        end
        n   = 0;
        dst = 23;
        for (int src = 23; src >= 0; src--)
        begin
            if (&ref_board[src])
                n++;
            else
            begin
                nb[dst] = ref_board[src];
                dst--;
            end
        end
        for (int i = dst; i >= 0; i--)
            nb[i] = '0;
        for (int i = 0; i < 24; i++)
            ref_board[i] = nb[i];
    endtask

    task automatic start_lock(input string name, input int col, input int row,
                              input logic [15:0] shp);
        int n;
        lock_model(col, row, shp, n);
        exp_lines = n;
        lock_name = name;
        piece_x   = 10'(playfield_pkg::x_origin + playfield_pkg::cell_px * col);
        piece_y   = 10'(playfield_pkg::cell_px * row);
        shape     = shp;
        lock      = 1'b1;
        @(negedge clk);
        lock = 1'b0;
    endtask

    task automatic finish_lock();
        while (busy)
            @(negedge clk);
    endtask

    assert property (@(posedge clk) disable iff (!arst_n) check_done |-> move_ok == exp_ok)
    else
    begin
        $display("Error: %s expected %0d actual %0d", test_name, exp_ok, $sampled(move_ok));
        fail_run();
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        check && exp_fast |-> ##2 check_done)
    else
    begin
        $display("%s: an out-of-bounds check did not finish two cycles after check", test_name);
        fail_run();
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        lock_done |-> int'(lines_cleared) == exp_lines)
    else
    begin
        $display("Error: %s expected %0d actual %0d", lock_name, exp_lines,
                 $sampled(lines_cleared));
        fail_run();
    end

    assert property (@(posedge clk) disable iff (!arst_n) lock |=> busy)
    else
    begin
        $display("%s: busy did not rise after the lock", lock_name);
        fail_run();
    end

    assert property (@(posedge clk) disable iff (!arst_n) lock_done |=> !busy)
    else
    begin
        $display("%s: busy stayed high after lock_done", lock_name);
        fail_run();
    end

    assert property (@(posedge clk) !arst_n |-> !busy && !check_done && !lock_done)
    else
    begin
        $display("busy, check_done or lock_done is high during reset");
        fail_run();
    end

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < max_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("the DUT hangs, the run hit its cycle limit");
        fail_run();
    end

    initial
    begin
        int c;
        int r;
        int d;
        int s;
        int k;
        int n;
        arst_n    = 1'b0;
        check     = 1'b0;
        lock      = 1'b0;
        dir       = playfield_pkg::dir_spawn;
        piece_x   = '0;
        piece_y   = '0;
        shape     = '0;
        lfsr      = 16'd56182;
        exp_ok    = 1'b0;
        exp_fast  = 1'b0;
        exp_lines = 0;
        test_name = "reset";
        lock_name = "reset";
        for (int i = 0; i < 24; i++)
            ref_board[i] = '0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        for (int row = 0; row < 24; row += 2) // a square on every cell pair of the empty board
        begin
            for (int col = 0; col < 10; col += 2)
                do_check("reset_sweep", col, row, playfield_pkg::dir_spawn, 16'h0033);
        end

        for (int i = 0; i < 40; i++)
        begin
            take_bits(2, c);
            take_bits(4, r);
            take_bits(2, d);
            take_bits(16, s);
            do_check("empty_random", 1 + c, r, 2'(d), (s == 0) ? 16'h0001 : 16'(s));
        end

        do_check("bounds_left", 0, 5, playfield_pkg::dir_left, 16'h1111);
        do_check("bounds_right", 6, 5, playfield_pkg::dir_right, 16'h8888);
        do_check("bounds_floor", 3, 23, playfield_pkg::dir_down, 16'h000F);
        do_check("bounds_floor_box", 2, 20, playfield_pkg::dir_down, 16'h1000);

        start_lock("overlap_lock", 4, 22, 16'h0033);
        finish_lock();
        do_check("overlap_hit", 5, 22, playfield_pkg::dir_spawn, 16'h0001);
        do_check("overlap_shift", 6, 22, playfield_pkg::dir_spawn, 16'h0033);
        do_check("overlap_right", 2, 22, playfield_pkg::dir_right, 16'h0033);
        do_check("overlap_above", 4, 19, playfield_pkg::dir_down, 16'h0033);
        do_check("overlap_drop", 4, 20, playfield_pkg::dir_down, 16'h0033);

        start_lock("clear_cell", 0, 21, 16'h0001); // rides down when the rows below go
        finish_lock();
        for (int col = 0; col < 10; col += 2)
        begin
            if (col != 4)
            begin
                start_lock("clear_two", col, 22, 16'h0033);
                finish_lock();
            end
        end
        do_check("clear_dropped", 0, 23, playfield_pkg::dir_spawn, 16'h0001);
        do_check("clear_above", 0, 21, playfield_pkg::dir_spawn, 16'h0001);
        do_check("clear_empty", 4, 22, playfield_pkg::dir_spawn, 16'h0033);
        for (int col = 0; col < 10; col++)
        begin
            start_lock("clear_four", col, 20, 16'h1111);
            finish_lock();
        end

        for (int i = 0; i < 16; i++)
        begin
            take_bits(2, k);
            take_bits(4, c);
            case (k)
                0:       start_lock("random_lock", c % 7, 23, 16'h000F);
                1:       start_lock("random_lock", c % 9, 22, 16'h0033);
                2:       start_lock("random_lock", c % 10, 20, 16'h1111);
                default: start_lock("random_lock", c % 10, 23, 16'h0001);
            endcase
            finish_lock();
            take_bits(3, c);
            take_bits(5, r);
            take_bits(2, d);
            take_bits(16, s);
            do_check("random_check", c, r % 24, 2'(d), (s == 0) ? 16'h0001 : 16'(s));
        end

        for (int i = 0; i < 6; i++)
        begin
            take_bits(4, c);
            start_lock("contention_lock", c % 9, 8, 16'h0033);
            n = 0;
            while (busy && n < 3) // rows 10 and down stay as they are through this lock
            begin
                take_bits(3, c);
                take_bits(4, r);
                take_bits(2, d);
                take_bits(16, s);
                do_check("contention_check", c, 10 + r % 10, 2'(d),
                         (s == 0) ? 16'h0001 : 16'(s));
                n++;
            end
            finish_lock();
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule
